// ==== src.f ====
design/cpuPkg.sv
design/control.sv
design/alu.sv
design/regFile.sv
design/fetchUnit.sv
design/instrQueue.sv
design/executeUnit.sv
design/cpuTop.sv
tb/clockGen.sv
tb/cpuTb.sv

// ==== tb/cpuTb.sv ====
// Testbench for the WISC core; loads directed programs and checks retire records and memory requests
`timescale 1ns/1ns
`default_nettype none

module cpuTb
	import cpuPkg::*;
();

	localparam int          STIM_DELAY      = 1;
	localparam int          MAX_TEST_CYCLES = 64 * 4;
	localparam int          WATCHDOG_NS     = 6 * 64 * 4 * 8;
	localparam logic [15:0] HALT_WORD       = 16'h0000;

	logic        clk;
	logic        arstN;
	logic        resetReq;
	logic [15:0] imemAddr;
	logic [15:0] imemData;
	dmemReqT     dmemReq;
	logic [15:0] dmemRdata;
	retireT      retire;
	logic        halted;

	logic [15:0] imem [256];
	logic [15:0] dmem [256];
	logic [15:0] regs [8];
	logic [15:0] progPc;
	retireT      expQ [$];
	retireT      gotQ [$];
	dmemReqT     expReqQ [$];
	dmemReqT     reqQ [$];
	int          checkCount;
	int          seedValue;

	clockGen clkGen (
		.clk      (clk),
		.arstN    (arstN),
		.resetReq (resetReq)
	);

	cpuTop #(
		.QUEUE_DEPTH (QUEUE_DEPTH_DEFAULT)
	) UUT (
		.clk       (clk),
		.arstN     (arstN),
		.imemAddr  (imemAddr),
		.imemData  (imemData),
		.dmemReq   (dmemReq),
		.dmemRdata (dmemRdata),
		.retire    (retire),
		.halted    (halted)
	);

	// Both memories answer 1 ns after the edge, from the address of the current cycle
	always @(posedge clk) begin
		#STIM_DELAY;
		imemData  = imem[imemAddr[8:1]];
		dmemRdata = dmem[dmemReq.addr[8:1]];
	end

	always @(posedge clk) begin
		if (arstN && dmemReq.en && dmemReq.write) begin
			dmem[dmemReq.addr[8:1]] <= dmemReq.wdata;
		end
	end

	always @(negedge clk) begin
		if (arstN) begin
			if (retire.valid) begin
				gotQ.push_back(retire);
			end
			if (dmemReq.en) begin
				reqQ.push_back(dmemReq);
			end
		end
	end

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1);
	endtask

	function automatic logic [15:0] encR(input opcodeT op, input logic [2:0] rs,
		input logic [2:0] rt, input logic [2:0] rd, input logic [1:0] func);
		return {op, rs, rt, rd, func};
	endfunction

	function automatic logic [15:0] encImm5(input opcodeT op, input logic [2:0] rs,
		input logic [2:0] rd, input logic [4:0] imm);
		return {op, rs, rd, imm};
	endfunction

	function automatic logic [15:0] encImm8(input opcodeT op, input logic [2:0] rs,
		input logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	function automatic logic [15:0] encDisp(input opcodeT op, input logic [10:0] disp);
		return {op, disp};
	endfunction

	function automatic logic [15:0] rotl(input logic [15:0] v, input int n);
		logic [15:0] r;
		r = v;
		for (int i = 0; i < n; i++) begin
			r = {r[14:0], r[15]};
		end
		return r;
	endfunction

	function automatic logic [15:0] rotr(input logic [15:0] v, input int n);
		logic [15:0] r;
		r = v;
		for (int i = 0; i < n; i++) begin
			r = {r[0], r[15:1]};
		end
		return r;
	endfunction

	// Bit 0 ends up in the MSB
	function automatic logic [15:0] reverseBits(input logic [15:0] v);
		logic [15:0] r;
		r = '0;
		for (int i = 0; i < 16; i++) begin
			r = {r[14:0], v[i]};
		end
		return r;
	endfunction

	function automatic logic [15:0] dmemFill(input logic [7:0] idx);
		return {idx, ~idx} ^ 16'h3C5A;
	endfunction

	task automatic startProgram();
		for (int i = 0; i < 256; i++) begin
			imem[i] = {OP_HALT, 11'(i)};
			dmem[i] = dmemFill(8'(i));
		end
		for (int i = 0; i < 8; i++) begin
			regs[i] = '0;
		end
		expQ.delete();
		expReqQ.delete();
		progPc = '0;
	endtask

	task automatic placeWord(input logic [15:0] word);
		imem[progPc[8:1]] = word;
		progPc = progPc + 16'd2;
	endtask

	task automatic expectWrite(input logic [15:0] word, input logic [2:0] dest,
		input logic [15:0] value);
		retireT rec;
		rec          = '0;
		rec.valid    = 1'b1;
		rec.pc       = progPc;
		rec.regWrite = 1'b1;
		rec.dest     = dest;
		rec.value    = value;
		expQ.push_back(rec);
		regs[dest] = value;
		placeWord(word);
	endtask

	task automatic expectNoWrite(input logic [15:0] word);
		retireT rec;
		rec       = '0;
		rec.valid = 1'b1;
		rec.pc    = progPc;
		expQ.push_back(rec);
		placeWord(word);
	endtask

	task automatic expectReq(input logic write, input logic [15:0] addr, input logic [15:0] wdata);
		dmemReqT req;
		req.en    = 1'b1;
		req.write = write;
		req.addr  = addr;
		req.wdata = wdata;
		expReqQ.push_back(req);
	endtask

	// lbi sets the high byte, slbi shifts it up and adds the low byte
	task automatic loadConst(input logic [2:0] r, input logic [15:0] v);
		expectWrite(encImm8(OP_LBI, r, v[15:8]), r, {{8{v[15]}}, v[15:8]});
		expectWrite(encImm8(OP_SLBI, r, v[7:0]), r, {regs[r][7:0], v[7:0]});
	endtask

	task automatic checkRetire(input retireT expected, input retireT actual, input string name,
		input int index);
		if (actual.pc !== expected.pc || actual.regWrite !== expected.regWrite ||
			(expected.regWrite && (actual.dest !== expected.dest ||
			actual.value !== expected.value))) begin
			abortRun($sformatf(
				"[ERROR] %0t: %s retire %0d expected pc %h wr %b r%0d=%h, got pc %h wr %b r%0d=%h",
				$time, name, index, expected.pc, expected.regWrite, expected.dest, expected.value,
				actual.pc, actual.regWrite, actual.dest, actual.value));
		end
		checkCount++;
	endtask

	task automatic checkDmemReq(input dmemReqT expected, input dmemReqT actual, input string name,
		input int index);
		if (actual.en !== expected.en || actual.write !== expected.write ||
			actual.addr !== expected.addr ||
			(expected.write && actual.wdata !== expected.wdata)) begin
			abortRun($sformatf(
				"[ERROR] %0t: %s request %0d expected wr %b addr %h data %h, got wr %b addr %h data %h",
				$time, name, index, expected.write, expected.addr, expected.wdata,
				actual.write, actual.addr, actual.wdata));
		end
		checkCount++;
	endtask

	task automatic runProgram(input string name);
		int cycles;
		gotQ.delete();
		reqQ.delete();
		@(posedge clk);
		#STIM_DELAY;
		resetReq = 1'b1;
		@(posedge clk);
		#STIM_DELAY;
		resetReq = 1'b0;
		@(posedge arstN);
		cycles = 0;
		while (!halted && cycles < MAX_TEST_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			abortRun($sformatf("Test %s: the core did not halt within %0d cycles",
				name, MAX_TEST_CYCLES));
		end
		// Anything retiring after the halt would show up here
		repeat (8) @(negedge clk);
		if (!halted) begin
			abortRun($sformatf("Test %s: halted dropped after the core stopped", name));
		end
		for (int i = 0; i < expQ.size() && i < gotQ.size(); i++) begin
			checkRetire(expQ[i], gotQ[i], name, i);
		end
		if (gotQ.size() != expQ.size()) begin
			abortRun($sformatf("[ERROR] %0t: %s retired %0d instructions, expected %0d",
				$time, name, gotQ.size(), expQ.size()));
		end
		for (int i = 0; i < expReqQ.size() && i < reqQ.size(); i++) begin
			checkDmemReq(expReqQ[i], reqQ[i], name, i);
		end
		if (reqQ.size() != expReqQ.size()) begin
			abortRun($sformatf("[ERROR] %0t: %s issued %0d memory requests, expected %0d",
				$time, name, reqQ.size(), expReqQ.size()));
		end
	endtask

	task automatic testImmOps();
		logic [15:0] a;
		startProgram();
		a = 16'($urandom);
		loadConst(3'd1, a);
		expectWrite(encImm5(OP_ADDI, 3'd1, 3'd2, 5'h0D), 3'd2, a + 16'd13);
		expectWrite(encImm5(OP_ADDI, 3'd1, 3'd3, 5'h1C), 3'd3, a - 16'd4);
		// subi is the immediate minus Rs
		expectWrite(encImm5(OP_SUBI, 3'd1, 3'd4, 5'h07), 3'd4, 16'd7 - a);
		expectWrite(encImm5(OP_SUBI, 3'd1, 3'd5, 5'h1F), 3'd5, 16'hFFFF - a);
		expectWrite(encImm5(OP_XORI, 3'd1, 3'd6, 5'h15), 3'd6, a ^ 16'h0015);
		expectWrite(encImm5(OP_ANDI, 3'd1, 3'd7, 5'h1B), 3'd7, a & 16'h001B);
		expectWrite(encImm5(OP_ROLI, 3'd1, 3'd2, 5'h05), 3'd2, rotl(a, 5));
		// Only the low 4 bits count as the amount
		expectWrite(encImm5(OP_SLLI, 3'd1, 3'd3, 5'h13), 3'd3, a << 3);
		expectWrite(encImm5(OP_RORI, 3'd1, 3'd4, 5'h0B), 3'd4, rotr(a, 11));
		expectWrite(encImm5(OP_SRLI, 3'd1, 3'd5, 5'h1E), 3'd5, a >> 14);
		expectWrite(encImm5(OP_ROLI, 3'd1, 3'd6, 5'h10), 3'd6, a);
		placeWord(HALT_WORD);
		runProgram("immediate ops");
	endtask

	task automatic testRegOps();
		logic [15:0] a;
		logic [15:0] b;
		logic [16:0] wide;
		startProgram();
		for (int round = 0; round < 2; round++) begin
			a = 16'($urandom);
			// Equal operands on the second pass
			b = (round == 0) ? 16'($urandom) : a;
			wide = {1'b0, a} + {1'b0, b};
			loadConst(3'd1, a);
			loadConst(3'd2, b);
			expectWrite(encR(OP_ALU, 3'd1, 3'd2, 3'd3, 2'b00), 3'd3, a + b);
			expectWrite(encR(OP_ALU, 3'd1, 3'd2, 3'd4, 2'b01), 3'd4, b - a);
			expectWrite(encR(OP_ALU, 3'd1, 3'd2, 3'd5, 2'b10), 3'd5, a ^ b);
			expectWrite(encR(OP_ALU, 3'd1, 3'd2, 3'd6, 2'b11), 3'd6, a & ~b);
			expectWrite(encR(OP_SHIFT, 3'd1, 3'd2, 3'd7, 2'b00), 3'd7, rotl(a, int'(b[3:0])));
			expectWrite(encR(OP_SHIFT, 3'd1, 3'd2, 3'd3, 2'b01), 3'd3, a << b[3:0]);
			expectWrite(encR(OP_SHIFT, 3'd1, 3'd2, 3'd4, 2'b10), 3'd4, rotr(a, int'(b[3:0])));
			expectWrite(encR(OP_SHIFT, 3'd1, 3'd2, 3'd5, 2'b11), 3'd5, a >> b[3:0]);
			expectWrite(encR(OP_SEQ, 3'd1, 3'd2, 3'd6, 2'b00), 3'd6, {15'd0, a == b});
			expectWrite(encR(OP_SLT, 3'd1, 3'd2, 3'd7, 2'b00), 3'd7,
				{15'd0, $signed(a) < $signed(b)});
			expectWrite(encR(OP_SLE, 3'd1, 3'd2, 3'd3, 2'b00), 3'd3,
				{15'd0, $signed(a) <= $signed(b)});
			expectWrite(encR(OP_SCO, 3'd1, 3'd2, 3'd4, 2'b00), 3'd4, {15'd0, wide[16]});
			expectWrite(encR(OP_BTR, 3'd1, 3'd0, 3'd5, 2'b00), 3'd5, reverseBits(a));
		end
		placeWord(HALT_WORD);
		runProgram("register ops");
	endtask

	task automatic testConstLink();
		startProgram();
		loadConst(3'd3, 16'hBEEF);
		loadConst(3'd4, 16'h1234);
		expectWrite(encDisp(OP_JAL, 11'd4), 3'd7, progPc + 16'd2);
		placeWord(encImm5(OP_ADDI, 3'd3, 3'd3, 5'd1));
		placeWord(encImm5(OP_ADDI, 3'd4, 3'd4, 5'd1));
		expectWrite(encImm8(OP_LBI, 3'd5, 8'h40), 3'd5, 16'h0040);
		// Target 0x50
		expectWrite(encImm8(OP_JALR, 3'd5, 8'h10), 3'd7, progPc + 16'd2);
		placeWord(encImm5(OP_ADDI, 3'd3, 3'd3, 5'd2));
		placeWord(encImm5(OP_ADDI, 3'd4, 3'd4, 5'd2));
		progPc = 16'h0050;
		expectWrite(encR(OP_ALU, 3'd7, 3'd3, 3'd2, 2'b00), 3'd2, regs[7] + regs[3]);
		placeWord(HALT_WORD);
		runProgram("constants and links");
	endtask

	task automatic testMemory();
		logic [15:0] d;
		startProgram();
		d = 16'($urandom);
		expectWrite(encImm8(OP_LBI, 3'd1, 8'h40), 3'd1, 16'h0040);
		loadConst(3'd2, d);
		expectNoWrite(encImm5(OP_ST, 3'd1, 3'd2, 5'h04));
		expectReq(1'b1, 16'h0044, d);
		expectWrite(encImm5(OP_LD, 3'd1, 3'd3, 5'h04), 3'd3, d);
		expectReq(1'b0, 16'h0044, 16'h0000);
		// Negative offset reads untouched fill data
		expectWrite(encImm5(OP_LD, 3'd1, 3'd4, 5'h1E), 3'd4, dmemFill(8'h1F));
		expectReq(1'b0, 16'h003E, 16'h0000);
		expectWrite(encImm5(OP_STU, 3'd1, 3'd2, 5'h06), 3'd1, 16'h0046);
		expectReq(1'b1, 16'h0046, d);
		expectWrite(encImm5(OP_LD, 3'd1, 3'd5, 5'h00), 3'd5, d);
		expectReq(1'b0, 16'h0046, 16'h0000);
		placeWord(HALT_WORD);
		runProgram("memory");
	endtask

	task automatic testBranches();
		logic [15:0] jumpPc;
		logic [15:0] backPc;
		startProgram();
		expectWrite(encImm8(OP_LBI, 3'd1, 8'h00), 3'd1, 16'h0000);
		expectWrite(encImm8(OP_LBI, 3'd2, 8'h05), 3'd2, 16'h0005);
		expectWrite(encImm8(OP_LBI, 3'd3, 8'hFD), 3'd3, 16'hFFFD);
		expectNoWrite(encImm8(OP_BEQZ, 3'd1, 8'd2));
		placeWord(encImm5(OP_ADDI, 3'd1, 3'd1, 5'd1));
		expectNoWrite(encImm8(OP_BEQZ, 3'd2, 8'd2));
		expectNoWrite(encImm8(OP_BNEZ, 3'd2, 8'd4));
		placeWord(encImm5(OP_ADDI, 3'd1, 3'd1, 5'd2));
		placeWord(encImm5(OP_ADDI, 3'd1, 3'd1, 5'd3));
		expectNoWrite(encImm8(OP_BNEZ, 3'd1, 8'd4));
		expectNoWrite(encImm8(OP_BLTZ, 3'd3, 8'd2));
		placeWord(encImm5(OP_ADDI, 3'd1, 3'd1, 5'd4));
		expectNoWrite(encImm8(OP_BLTZ, 3'd2, 8'd2));
		expectNoWrite(encImm8(OP_BGEZ, 3'd2, 8'd2));
		placeWord(encImm5(OP_ADDI, 3'd1, 3'd1, 5'd5));
		expectNoWrite(encImm8(OP_BGEZ, 3'd3, 8'd2));
		expectWrite(encImm5(OP_ADDI, 3'd2, 3'd4, 5'd1), 3'd4, regs[2] + 16'd1);
		// Out to 0x60 and back again behind the skipped word
		jumpPc = progPc;
		expectNoWrite(encDisp(OP_J, 11'(16'h0060 - (jumpPc + 16'd2))));
		placeWord(encImm5(OP_ADDI, 3'd1, 3'd1, 5'd6));
		backPc = progPc;
		progPc = 16'h0060;
		expectWrite(encImm5(OP_ADDI, 3'd2, 3'd5, 5'h1F), 3'd5, regs[2] - 16'd1);
		expectNoWrite(encDisp(OP_J, 11'(backPc - (progPc + 16'd2))));
		placeWord(encImm5(OP_ADDI, 3'd1, 3'd1, 5'd7));
		progPc = backPc;
		expectWrite(encImm8(OP_LBI, 3'd6, 8'h70), 3'd6, 16'h0070);
		expectNoWrite(encImm8(OP_JR, 3'd6, 8'h04));
		placeWord(encImm5(OP_ADDI, 3'd1, 3'd1, 5'd8));
		progPc = 16'h0074;
		placeWord(HALT_WORD);
		runProgram("branches and jumps");
	endtask

	task automatic testHaltIllegal();
		startProgram();
		expectWrite(encImm8(OP_LBI, 3'd1, 8'h11), 3'd1, 16'h0011);
		// siic and rti
		expectNoWrite({5'b00010, 3'd1, 3'd1, 5'd0});
		expectNoWrite({5'b00011, 3'd1, 3'd1, 5'd0});
		expectNoWrite(encImm8(OP_NOP, 3'd0, 8'd0));
		expectWrite(encImm5(OP_ADDI, 3'd1, 3'd2, 5'd1), 3'd2, regs[1] + 16'd1);
		placeWord(HALT_WORD);
		placeWord(encImm5(OP_ADDI, 3'd1, 3'd3, 5'd2));
		placeWord(encImm5(OP_ADDI, 3'd1, 3'd4, 5'd3));
		runProgram("halt and illegal");
	endtask

	initial begin
		#WATCHDOG_NS;
		abortRun("Watchdog expired before all tests finished");
	end

	initial begin
		seedValue  = 6;
		void'($urandom(seedValue));
		resetReq   = 1'b0;
		imemData   = '0;
		dmemRdata  = '0;
		checkCount = 0;
		testImmOps();
		testRegOps();
		testConstLink();
		testMemory();
		testBranches();
		testHaltIllegal();
		if (checkCount > 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			abortRun("No checks were executed");
		end
	end

endmodule

`default_nettype wire

// ==== tb/clockGen.sv ====
// Testbench clock and reset source; a pulse on resetReq restarts the reset sequence
`timescale 1ns/1ns
`default_nettype none

module clockGen (
	output logic clk,
	output logic arstN,
	input  logic resetReq
);

	localparam int HALF_PERIOD  = 4;
	localparam int RESET_CYCLES = 4;

	int rstCount;

	initial begin
		clk      = 1'b0;
		arstN    = 1'b0;
		rstCount = 0;
	end

	always #HALF_PERIOD clk = ~clk;

	// Release on a falling edge, away from the rising edges the core uses
	always @(negedge clk or posedge resetReq) begin
		if (resetReq) begin
			arstN    <= 1'b0;
			rstCount <= 0;
		end else if (rstCount == RESET_CYCLES - 1) begin
			arstN <= 1'b1;
		end else begin
			rstCount <= rstCount + 1;
		end
	end

endmodule

`default_nettype wire

// ==== design/cpuTop.sv ====
// Core top level; connects fetch, instruction queue and execute and exposes both memory ports
`timescale 1ns/1ns
`default_nettype none

module cpuTop
	import cpuPkg::*;
#(
	parameter int QUEUE_DEPTH = QUEUE_DEPTH_DEFAULT
) (
	input  logic        clk,
	input  logic        arstN,
	output logic [15:0] imemAddr,
	input  logic [15:0] imemData,
	output dmemReqT     dmemReq,
	input  logic [15:0] dmemRdata,
	output retireT      retire,
	output logic        halted
);

	logic     pushValid;
	logic     pushReady;
	qEntryT   pushData;
	logic     popValid;
	logic     popReady;
	qEntryT   popData;
	redirectT redirect;

	fetchUnit uFetch (
		.clk       (clk),
		.arstN     (arstN),
		.imemAddr  (imemAddr),
		.imemData  (imemData),
		.pushValid (pushValid),
		.pushData  (pushData),
		.pushReady (pushReady),
		.redirect  (redirect),
		.halted    (halted)
	);

	instrQueue #(
		.DEPTH (QUEUE_DEPTH)
	) uQueue (
		.clk       (clk),
		.arstN     (arstN),
		.flush     (redirect.valid),
		.pushValid (pushValid),
		.pushData  (pushData),
		.pushReady (pushReady),
		.popValid  (popValid),
		.popData   (popData),
		.popReady  (popReady)
	);

	executeUnit uExecute (
		.clk       (clk),
		.arstN     (arstN),
		.popValid  (popValid),
		.popData   (popData),
		.popReady  (popReady),
		.redirect  (redirect),
		.dmemReq   (dmemReq),
		.dmemRdata (dmemRdata),
		.retire    (retire),
		.halted    (halted)
	);

endmodule

`default_nettype wire

// ==== design/executeUnit.sv ====
// Execute stage; pops one instruction per cycle, resolves it completely and records the retire
`timescale 1ns/1ns
`default_nettype none

module executeUnit
	import cpuPkg::*;
(
	input  logic        clk,
	input  logic        arstN,
	input  logic        popValid,
	input  qEntryT      popData,
	output logic        popReady,
	output redirectT    redirect,
	output dmemReqT     dmemReq,
	input  logic [15:0] dmemRdata,
	output retireT      retire,
	output logic        halted
);

	ctrlT        ctrl;
	logic        popFire;
	logic [15:0] instr;
	logic [15:0] pcPlus2;
	logic [15:0] imm;
	logic [15:0] rsData;
	logic [15:0] rtData;
	logic [15:0] aluB;
	logic [15:0] aluResult;
	logic [15:0] jumpBase;
	logic [15:0] wrData;
	logic [2:0]  dest;
	logic        taken;
	logic        isJump;
	logic        isLink;

	assign instr    = popData.instr;
	assign popReady = !halted;
	assign popFire  = popValid && popReady;
	assign pcPlus2  = popData.pc + 16'd2;

	control uControl (
		.instr (instr),
		.ctrl  (ctrl)
	);

	regFile uRegFile (
		.clk     (clk),
		.arstN   (arstN),
		.rdAddrA (instr[10:8]),
		.rdAddrB (instr[7:5]),
		.rdDataA (rsData),
		.rdDataB (rtData),
		.wrEn    (popFire && ctrl.regWrite),
		.wrAddr  (dest),
		.wrData  (wrData)
	);

	alu uAlu (
		.op     (ctrl.aluOp),
		.a      (rsData),
		.b      (aluB),
		.result (aluResult)
	);

	always_comb begin
		case (ctrl.immKind)
			IMM_IMM5SEXT: imm = {{11{instr[4]}}, instr[4:0]};
			IMM_IMM5ZEXT: imm = {11'd0, instr[4:0]};
			IMM_IMM8SEXT: imm = {{8{instr[7]}}, instr[7:0]};
			IMM_IMM8ZEXT: imm = {8'd0, instr[7:0]};
			IMM_DISP11:   imm = {{5{instr[10]}}, instr[10:0]};
			default:      imm = '0;
		endcase
	end

	assign aluB = ctrl.useImm ? imm : rtData;

	// Branches test Rs against zero
	always_comb begin
		case (ctrl.brCond)
			BR_EQZ:  taken = (rsData == '0);
			BR_NEZ:  taken = (rsData != '0);
			BR_LTZ:  taken = rsData[15];
			BR_GEZ:  taken = !rsData[15];
			default: taken = 1'b0;
		endcase
	end

	assign isJump   = (ctrl.jumpKind != JMP_NONE);
	assign isLink   = (ctrl.jumpKind == JMP_DISPLINK) || (ctrl.jumpKind == JMP_REGLINK);
	assign jumpBase = (ctrl.jumpKind == JMP_REG || ctrl.jumpKind == JMP_REGLINK) ? rsData : pcPlus2;

	assign redirect.valid  = popFire && (taken || isJump);
	assign redirect.target = jumpBase + imm;

	always_comb begin
		case (ctrl.destSel)
			DEST_RD_R: dest = instr[4:2];
			DEST_RD_I: dest = instr[7:5];
			DEST_RS:   dest = instr[10:8];
			default:   dest = 3'd7;
		endcase
	end

	assign dmemReq.en    = popFire && (ctrl.memRead || ctrl.memWrite);
	assign dmemReq.write = popFire && ctrl.memWrite;
	assign dmemReq.addr  = aluResult;
	assign dmemReq.wdata = rtData;

	always_comb begin
		if (ctrl.memRead) begin
			wrData = dmemRdata;
		end else if (isLink) begin
			wrData = pcPlus2;
		end else if (ctrl.stu) begin
			wrData = dmemReq.addr;
		end else if (ctrl.slbi) begin
			wrData = {rsData[7:0], instr[7:0]};
		end else if (ctrl.lbi) begin
			wrData = imm;
		end else begin
			wrData = aluResult;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			retire <= '0;
			halted <= 1'b0;
		end else begin
			retire.valid <= popFire && !ctrl.halt;
			if (popFire) begin
				retire.pc       <= popData.pc;
				retire.regWrite <= ctrl.regWrite;
				retire.dest     <= dest;
				retire.value    <= wrData;
			end
			if (popFire && ctrl.halt) begin
				halted <= 1'b1;
			end
		end
	end

	noRetireAfterHalt: assert property (@(posedge clk) disable iff (!arstN)
		halted |=> !retire.valid);

endmodule

`default_nettype wire

// ==== design/instrQueue.sv ====
// Instruction queue between fetch and execute; circular FIFO emptied by a redirect flush
`timescale 1ns/1ns
`default_nettype none

module instrQueue
	import cpuPkg::*;
#(
	parameter int DEPTH = QUEUE_DEPTH_DEFAULT
) (
	input  logic   clk,
	input  logic   arstN,
	input  logic   flush,
	input  logic   pushValid,
	input  qEntryT pushData,
	output logic   pushReady,
	output logic   popValid,
	output qEntryT popData,
	input  logic   popReady
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	qEntryT             mem [DEPTH];
	logic [PTR_W-1:0]   wrPtr;
	logic [PTR_W-1:0]   rdPtr;
	logic [CNT_W-1:0]   count;
	logic               pushFire;
	logic               popFire;

	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign pushReady = (count != CNT_W'(DEPTH));
	assign popValid  = (count != '0);
	assign popData   = mem[rdPtr];
	assign pushFire  = pushValid && pushReady;
	assign popFire   = popValid && popReady;

	always_ff @(posedge clk) begin
		if (pushFire && !flush) begin
			mem[wrPtr] <= pushData;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else if (flush) begin
			// A push in the flush cycle is dropped as well
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (pushFire) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (popFire) begin
				rdPtr <= nextPtr(rdPtr);
			end
			if (pushFire && !popFire) begin
				count <= count + 1'b1;
			end else if (popFire && !pushFire) begin
				count <= count - 1'b1;
			end
		end
	end

	noPushWhenFull: assert property (@(posedge clk) disable iff (!arstN)
		(count == CNT_W'(DEPTH)) && !popFire && !flush |=> count == CNT_W'(DEPTH));

	noPopWhenEmpty: assert property (@(posedge clk) disable iff (!arstN)
		(count == '0) && !pushValid |=> !popValid);

endmodule

`default_nettype wire

// ==== design/fetchUnit.sv ====
// Fetch stage; walks the PC through instruction memory and pushes words into the queue
`timescale 1ns/1ns
`default_nettype none

module fetchUnit
	import cpuPkg::*;
(
	input  logic        clk,
	input  logic        arstN,
	output logic [15:0] imemAddr,
	input  logic [15:0] imemData,
	output logic        pushValid,
	output qEntryT      pushData,
	input  logic        pushReady,
	input  redirectT    redirect,
	input  logic        halted
);

	logic [15:0] pc;
	logic        running;

	assign imemAddr       = pc;
	assign pushData.instr = imemData;
	assign pushData.pc    = pc;

	// First push one cycle out of reset
	assign pushValid = running && !halted;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc      <= '0;
			running <= 1'b0;
		end else begin
			running <= 1'b1;
			if (redirect.valid) begin
				pc <= redirect.target;
			end else if (pushValid && pushReady) begin
				pc <= pc + 16'd2;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
// Eight-entry register file; two combinational read ports and one write port at the clock edge
`timescale 1ns/1ns
`default_nettype none

module regFile (
	input  logic        clk,
	input  logic        arstN,
	input  logic [2:0]  rdAddrA,
	input  logic [2:0]  rdAddrB,
	output logic [15:0] rdDataA,
	output logic [15:0] rdDataB,
	input  logic        wrEn,
	input  logic [2:0]  wrAddr,
	input  logic [15:0] wrData
);

	logic [15:0] regs [8];

	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regs <= '{default: '0};
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

endmodule

`default_nettype wire

// ==== design/alu.sv ====
// 16-bit ALU for the execute stage; a is Rs, b is Rt or the selected immediate
`timescale 1ns/1ns
`default_nettype none

module alu
	import cpuPkg::*;
(
	input  aluOpT       op,
	input  logic [15:0] a,
	input  logic [15:0] b,
	output logic [15:0] result
);

	logic [16:0] sum;
	logic [3:0]  amt;
	logic [31:0] rolWide;
	logic [31:0] rorWide;
	logic [15:0] reversed;

	assign sum = {1'b0, a} + {1'b0, b};
	assign amt = b[3:0];

	// Rotates taken from a doubled copy of a
	assign rolWide = {a, a} << amt;
	assign rorWide = {a, a} >> amt;

	always_comb begin
		for (int i = 0; i < 16; i++) begin
			reversed[i] = a[15 - i];
		end
	end

	always_comb begin
		case (op)
			ALU_ADD:  result = sum[15:0];
			ALU_SUB:  result = b - a;
			ALU_XOR:  result = a ^ b;
			ALU_ANDN: result = a & ~b;
			ALU_AND:  result = a & b;
			ALU_ROL:  result = rolWide[31:16];
			ALU_SLL:  result = a << amt;
			ALU_ROR:  result = rorWide[15:0];
			ALU_SRL:  result = a >> amt;
			ALU_SEQ:  result = {15'd0, a == b};
			ALU_SLT:  result = {15'd0, $signed(a) < $signed(b)};
			ALU_SLE:  result = {15'd0, $signed(a) <= $signed(b)};
			ALU_SCO:  result = {15'd0, sum[16]};
			ALU_BTR:  result = reversed;
			default:  result = b;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/control.sv ====
// Instruction decoder; maps a WISC instruction word onto the control record used by execute
`timescale 1ns/1ns
`default_nettype none

module control
	import cpuPkg::*;
(
	input  logic [15:0] instr,
	output ctrlT        ctrl
);

	opcodeT     opcode;
	logic [1:0] func;

	assign opcode = opcodeT'(instr[15:11]);
	assign func   = instr[1:0];

	always_comb begin
		ctrl = '0;
		case (opcode)
			OP_HALT: ctrl.halt = 1'b1;
			OP_NOP: begin
			end
			OP_ADDI, OP_SUBI, OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
				ctrl.regWrite = 1'b1;
				ctrl.useImm   = 1'b1;
				ctrl.immKind  = IMM_IMM5SEXT;
				ctrl.destSel  = DEST_RD_I;
			end
			// Logic immediates are zero extended
			OP_XORI, OP_ANDI: begin
				ctrl.regWrite = 1'b1;
				ctrl.useImm   = 1'b1;
				ctrl.immKind  = IMM_IMM5ZEXT;
				ctrl.destSel  = DEST_RD_I;
			end
			OP_LD: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead  = 1'b1;
				ctrl.useImm   = 1'b1;
				ctrl.immKind  = IMM_IMM5SEXT;
				ctrl.destSel  = DEST_RD_I;
			end
			OP_ST: begin
				ctrl.memWrite = 1'b1;
				ctrl.useImm   = 1'b1;
				ctrl.immKind  = IMM_IMM5SEXT;
			end
			OP_STU: begin
				ctrl.memWrite = 1'b1;
				ctrl.stu      = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.useImm   = 1'b1;
				ctrl.immKind  = IMM_IMM5SEXT;
				ctrl.destSel  = DEST_RS;
			end
			OP_LBI, OP_SLBI: begin
				ctrl.regWrite = 1'b1;
				ctrl.useImm   = 1'b1;
				ctrl.lbi      = (opcode == OP_LBI);
				ctrl.slbi     = (opcode == OP_SLBI);
				ctrl.immKind  = (opcode == OP_LBI) ? IMM_IMM8SEXT : IMM_IMM8ZEXT;
				ctrl.destSel  = DEST_RS;
			end
			OP_BTR, OP_ALU, OP_SHIFT, OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
				ctrl.regWrite = 1'b1;
				ctrl.destSel  = DEST_RD_R;
			end
			OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
				ctrl.immKind = IMM_IMM8SEXT;
				ctrl.brCond  = brCondT'({1'b0, opcode[1:0]} + 3'd1);
			end
			OP_J, OP_JAL: begin
				ctrl.immKind  = IMM_DISP11;
				ctrl.jumpKind = (opcode == OP_JAL) ? JMP_DISPLINK : JMP_DISP;
				ctrl.regWrite = (opcode == OP_JAL);
				ctrl.destSel  = DEST_R7;
			end
			OP_JR, OP_JALR: begin
				ctrl.immKind  = IMM_IMM8SEXT;
				ctrl.jumpKind = (opcode == OP_JALR) ? JMP_REGLINK : JMP_REG;
				ctrl.regWrite = (opcode == OP_JALR);
				ctrl.destSel  = DEST_R7;
			end
			// siic, rti and unused opcodes fall through as a nop
			default: ctrl.illegal = 1'b1;
		endcase

		case (opcode)
			OP_SUBI: ctrl.aluOp = ALU_SUB;
			OP_XORI: ctrl.aluOp = ALU_XOR;
			OP_ANDI: ctrl.aluOp = ALU_AND;
			OP_ROLI: ctrl.aluOp = ALU_ROL;
			OP_SLLI: ctrl.aluOp = ALU_SLL;
			OP_RORI: ctrl.aluOp = ALU_ROR;
			OP_SRLI: ctrl.aluOp = ALU_SRL;
			OP_ALU: begin
				case (func)
					2'b00:   ctrl.aluOp = ALU_ADD;
					2'b01:   ctrl.aluOp = ALU_SUB;
					2'b10:   ctrl.aluOp = ALU_XOR;
					default: ctrl.aluOp = ALU_ANDN;
				endcase
			end
			OP_SHIFT: begin
				case (func)
					2'b00:   ctrl.aluOp = ALU_ROL;
					2'b01:   ctrl.aluOp = ALU_SLL;
					2'b10:   ctrl.aluOp = ALU_ROR;
					default: ctrl.aluOp = ALU_SRL;
				endcase
			end
			OP_SEQ:          ctrl.aluOp = ALU_SEQ;
			OP_SLT:          ctrl.aluOp = ALU_SLT;
			OP_SLE:          ctrl.aluOp = ALU_SLE;
			OP_SCO:          ctrl.aluOp = ALU_SCO;
			OP_BTR:          ctrl.aluOp = ALU_BTR;
			OP_LBI, OP_SLBI: ctrl.aluOp = ALU_PASSB;
			// Addresses of ld, st and stu come from the adder
			default:         ctrl.aluOp = ALU_ADD;
		endcase
	end

	aluOpKnown: assert final (!$isunknown(ctrl.aluOp));

endmodule

`default_nettype wire

// ==== design/cpuPkg.sv ====
// Shared types for the WISC core; imported by every design block that decodes or passes records
`default_nettype none

package cpuPkg;

	localparam int QUEUE_DEPTH_DEFAULT = 2;

	typedef enum logic [4:0] {
		OP_HALT  = 5'b00000,
		OP_NOP   = 5'b00001,
		OP_J     = 5'b00100,
		OP_JR    = 5'b00101,
		OP_JAL   = 5'b00110,
		OP_JALR  = 5'b00111,
		OP_ADDI  = 5'b01000,
		OP_SUBI  = 5'b01001,
		OP_XORI  = 5'b01010,
		OP_ANDI  = 5'b01011,
		OP_BEQZ  = 5'b01100,
		OP_BNEZ  = 5'b01101,
		OP_BLTZ  = 5'b01110,
		OP_BGEZ  = 5'b01111,
		OP_ST    = 5'b10000,
		OP_LD    = 5'b10001,
		OP_SLBI  = 5'b10010,
		OP_STU   = 5'b10011,
		OP_ROLI  = 5'b10100,
		OP_SLLI  = 5'b10101,
		OP_RORI  = 5'b10110,
		OP_SRLI  = 5'b10111,
		OP_LBI   = 5'b11000,
		OP_BTR   = 5'b11001,
		OP_SHIFT = 5'b11010,
		OP_ALU   = 5'b11011,
		OP_SEQ   = 5'b11100,
		OP_SLT   = 5'b11101,
		OP_SLE   = 5'b11110,
		OP_SCO   = 5'b11111
	} opcodeT;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_XOR, ALU_ANDN, ALU_AND,
		ALU_ROL, ALU_SLL, ALU_ROR, ALU_SRL,
		ALU_SEQ, ALU_SLT, ALU_SLE, ALU_SCO, ALU_BTR, ALU_PASSB
	} aluOpT;

	typedef enum logic [2:0] {BR_NONE, BR_EQZ, BR_NEZ, BR_LTZ, BR_GEZ} brCondT;

	typedef enum logic [2:0] {JMP_NONE, JMP_DISP, JMP_DISPLINK, JMP_REG, JMP_REGLINK} jumpKindT;

	typedef enum logic [2:0] {
		IMM_NONE, IMM_IMM5SEXT, IMM_IMM5ZEXT, IMM_IMM8SEXT, IMM_IMM8ZEXT, IMM_DISP11
	} immKindT;

	typedef enum logic [1:0] {DEST_RD_R, DEST_RD_I, DEST_RS, DEST_R7} destSelT;

	typedef struct packed {
		logic     regWrite;
		logic     memWrite;
		logic     memRead;
		logic     stu;
		logic     slbi;
		logic     lbi;
		logic     halt;
		logic     illegal;
		logic     useImm;
		aluOpT    aluOp;
		immKindT  immKind;
		brCondT   brCond;
		jumpKindT jumpKind;
		destSelT  destSel;
	} ctrlT;

	typedef struct packed {
		logic [15:0] instr;
		logic [15:0] pc;
	} qEntryT;

	typedef struct packed {
		logic        valid;
		logic [15:0] target;
	} redirectT;

	typedef struct packed {
		logic        en;
		logic        write;
		logic [15:0] addr;
		logic [15:0] wdata;
	} dmemReqT;

	typedef struct packed {
		logic        valid;
		logic [15:0] pc;
		logic        regWrite;
		logic [2:0]  dest;
		logic [15:0] value;
	} retireT;

endpackage

`default_nettype wire
